// ==== Makefile ====
# Verilator build and run of the compact float summer testbench

VERILATOR ?= verilator
TOP       ?= tb_cf_sum
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Simulation failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/cf_macros.svh ====
/*
 * compact float summation shared widths
 * field widths, lane count and summer latency
 */
`ifndef CF_MACROS_SVH
`define CF_MACROS_SVH

// exponent field width
`define CF_EXP_W 8

// fraction field width, hidden one not included
`define CF_FRAC_W 9

// whole float word, sign + exponent + fraction
`define CF_WIDTH 18

// max samples collected into one group
`define CF_LANES 4

// group sequence number width
`define CF_TAG_W 8

// summer latency in cycles, group valid to result valid
`define CF_PIPE_DEPTH 6

`endif

// ==== logic/cf_group_if.sv ====
/*
 * group bus between loader and summer
 * one collected group per valid strobe, no back-pressure
 */
`timescale 1ns/1ps
`include "cf_macros.svh"

interface cf_group_if;

  // single cycle strobe, the rest is only meaningful while it is high
  logic                                valid;
  cf_pkg::cfloat_u [`CF_LANES-1:0]     lanes;
  // lanes with a clear bit add nothing
  logic [`CF_LANES-1:0]                lane_en;
  logic [`CF_TAG_W-1:0]                tag;

  modport loader (
    output valid,
    output lanes,
    output lane_en,
    output tag
  );

  modport summer (
    input valid,
    input lanes,
    input lane_en,
    input tag
  );

endinterface

// ==== logic/cf_pkg.sv ====
/*
 * compact float package
 * float word views, special constants and group length type
 */
`include "cf_macros.svh"

package cf_pkg;

  // field view of one float word
  typedef struct packed {
    logic                  sign;
    logic [`CF_EXP_W-1:0]  exp;
    logic [`CF_FRAC_W-1:0] frac;
  } cfloat_s;

  // same word seen as raw bits or as fields
  typedef union packed {
    logic [`CF_WIDTH-1:0] raw;
    cfloat_s              f;
  } cfloat_u;

  // number of lanes minus one
  typedef logic [$clog2(`CF_LANES)-1:0] group_len_t;

  // full group, also the reset length
  localparam group_len_t GROUP_LEN_FULL = group_len_t'(`CF_LANES - 1);

  // quiet NaN with only the fraction msb set
  localparam logic [`CF_WIDTH-1:0] CF_QNAN = {
    1'b1,
    {`CF_EXP_W{1'b1}},
    1'b1,
    {(`CF_FRAC_W-1){1'b0}}
  };

  // exponent of zero, lanes carrying it count as zero
  localparam logic [`CF_EXP_W-1:0] CF_ZERO_EXP = '0;

endpackage

// ==== logic/cf_sum_top.sv ====
/*
 * compact float group summation top
 * config block, lane loader and six-stage summer
 */
`timescale 1ns/1ps
`include "cf_macros.svh"

module cf_sum_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // sample stream
  input  logic                 sample_valid,
  input  logic [`CF_WIDTH-1:0] sample_data,
  input  logic                 flush,
  // config bus
  input  logic                 cfg_we,
  input  logic                 cfg_addr,
  input  logic [7:0]           cfg_wdata,
  output logic [7:0]           cfg_rdata,
  // results, one per group
  output logic                 result_valid,
  output logic [`CF_WIDTH-1:0] result_sum,
  output logic [`CF_TAG_W-1:0] result_tag
);

  cf_pkg::group_len_t group_len;

  cf_group_if grp_bus ();

  sum_config i_sum_config (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .group_done (result_valid),
    .cfg_rdata  (cfg_rdata),
    .group_len  (group_len)
  );

  lane_loader i_lane_loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .flush        (flush),
    .group_len    (group_len),
    .grp          (grp_bus.loader)
  );

  group_sum i_group_sum (
    .clk       (clk),
    .rst_n     (rst_n),
    .grp       (grp_bus.summer),
    .out_valid (result_valid),
    .out_sum   (result_sum),
    .out_tag   (result_tag)
  );

endmodule

// ==== logic/group_sum.sv ====
/*
 * group-alignment float summer
 * six stages: max exponent, shift distance, align, add, lzc, normalize
 */
`timescale 1ns/1ps
`include "cf_macros.svh"

module group_sum (
  input  logic                 clk,
  input  logic                 rst_n,
  cf_group_if.summer           grp,
  output logic                 out_valid,
  output logic [`CF_WIDTH-1:0] out_sum,
  output logic [`CF_TAG_W-1:0] out_tag
);

  localparam int LANES   = `CF_LANES;
  localparam int EXP_W   = `CF_EXP_W;
  localparam int FRAC_W  = `CF_FRAC_W;
  localparam int DEPTH   = `CF_PIPE_DEPTH;
  // mantissa with hidden one, then with a sign bit
  localparam int MANT_W  = FRAC_W + 1;
  localparam int SMANT_W = MANT_W + 1;
  // lane sum, enough headroom for all lanes
  localparam int SUM_W   = SMANT_W + $clog2(LANES);
  localparam int LZC_W   = $clog2(SUM_W + 1);

  // valid and tag ride alongside the data
  logic [DEPTH-1:0]     vld_sr;
  logic [`CF_TAG_W-1:0] tag_sr [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[DEPTH-2:0], grp.valid};
    end
  end

  always_ff @(posedge clk) begin
    tag_sr[0] <= grp.tag;
    for (int s = 1; s < DEPTH; s++) begin
      tag_sr[s] <= tag_sr[s-1];
    end
  end

  assign out_valid = vld_sr[DEPTH-1];
  assign out_tag   = tag_sr[DEPTH-1];

  // stage 1, max exponent over live lanes and NaN detect
  logic [LANES-1:0]   live_c;
  logic [EXP_W-1:0]   e_max_c;
  logic               nan_c;
  cf_pkg::cfloat_u    lane_1 [LANES];
  logic [LANES-1:0]   live_1;
  logic [EXP_W-1:0]   e_max_1;
  logic               nan_1;

  always_comb begin
    e_max_c = cf_pkg::CF_ZERO_EXP;
    nan_c   = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      // exponent zero lanes are treated as zero, no hidden one
      live_c[i] = grp.lane_en[i] && (grp.lanes[i].f.exp != cf_pkg::CF_ZERO_EXP);
      if (live_c[i] && grp.lanes[i].f.exp > e_max_c) begin
        e_max_c = grp.lanes[i].f.exp;
      end
      nan_c = nan_c | (grp.lane_en[i] && (&grp.lanes[i].f.exp) && (grp.lanes[i].f.frac != '0));
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      lane_1[i] <= grp.lanes[i];
    end
    live_1  <= live_c;
    e_max_1 <= e_max_c;
    nan_1   <= nan_c;
  end

  // stage 2, distance of each lane below the max
  logic [EXP_W-1:0] shift_2 [LANES];
  cf_pkg::cfloat_u  lane_2  [LANES];
  logic [LANES-1:0] live_2;
  logic [EXP_W-1:0] e_max_2;
  logic             nan_2;

  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      shift_2[i] <= e_max_1 - lane_1[i].f.exp;
      lane_2[i]  <= lane_1[i];
    end
    live_2  <= live_1;
    e_max_2 <= e_max_1;
    nan_2   <= nan_1;
  end

  // stage 3, align with truncation and apply the sign
  logic [MANT_W-1:0]         mant_c [LANES];
  logic signed [SMANT_W-1:0] sm_3   [LANES];
  logic [EXP_W-1:0]          e_max_3;
  logic                      nan_3;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      mant_c[i] = live_2[i] ? ({1'b1, lane_2[i].f.frac} >> shift_2[i]) : '0;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      sm_3[i] <= lane_2[i].f.sign ? -{1'b0, mant_c[i]} : {1'b0, mant_c[i]};
    end
    e_max_3 <= e_max_2;
    nan_3   <= nan_2;
  end

  // stage 4, two's complement add
  logic signed [SUM_W-1:0] sum_c;
  logic signed [SUM_W-1:0] sum_4;
  logic [EXP_W-1:0]        e_max_4;
  logic                    nan_4;

  always_comb begin
    sum_c = '0;
    for (int i = 0; i < LANES; i++) begin
      sum_c = sum_c + SUM_W'(sm_3[i]);
    end
  end

  always_ff @(posedge clk) begin
    sum_4   <= sum_c;
    e_max_4 <= e_max_3;
    nan_4   <= nan_3;
  end

  // stage 5, magnitude and leading zero count
  logic [SUM_W-1:0] mag_c;
  logic [LZC_W-1:0] lzc_c;
  logic [SUM_W-1:0] mag_5;
  logic [LZC_W-1:0] lzc_5;
  logic             sign_5;
  logic [EXP_W-1:0] e_max_5;
  logic             nan_5;

  always_comb begin
    logic found;
    found = 1'b0;
    mag_c = sum_4[SUM_W-1] ? -sum_4 : sum_4;
    // all zero gives SUM_W
    lzc_c = LZC_W'(SUM_W);
    for (int b = SUM_W - 1; b >= 0; b--) begin
      if (!found && mag_c[b]) begin
        lzc_c = LZC_W'(SUM_W - 1 - b);
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    mag_5   <= mag_c;
    lzc_5   <= lzc_c;
    sign_5  <= sum_4[SUM_W-1];
    e_max_5 <= e_max_4;
    nan_5   <= nan_4;
  end

  // stage 6, normalize with truncation and pick specials
  logic [SUM_W-1:0] norm_c;
  cf_pkg::cfloat_u  res_c;

  always_comb begin
    // leading one lands on the msb
    norm_c = mag_5 << lzc_5;
    res_c  = '0;
    if (nan_5) begin
      res_c.raw = cf_pkg::CF_QNAN;
    end else if (mag_5 == '0) begin
      res_c.f.exp = cf_pkg::CF_ZERO_EXP;
    end else begin
      res_c.f.sign = sign_5;
      // hidden one sits SUM_W-MANT_W bits below the msb, exponent wraps
      res_c.f.exp  = e_max_5 + EXP_W'(SUM_W - MANT_W) - EXP_W'(lzc_5);
      res_c.f.frac = norm_c[SUM_W-2 -: FRAC_W];
    end
  end

  always_ff @(posedge clk) begin
    out_sum <= res_c.raw;
  end

endmodule

// ==== logic/lane_loader.sv ====
/*
 * serial to parallel lane loader
 * collects samples into groups of the configured length, flush sends a partial group
 */
`timescale 1ns/1ps
`include "cf_macros.svh"

module lane_loader (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sample_valid,
  input  logic [`CF_WIDTH-1:0] sample_data,
  input  logic                 flush,
  input  cf_pkg::group_len_t   group_len,
  cf_group_if.loader           grp
);

  localparam int CNT_W = $clog2(`CF_LANES);
  localparam int NL_W  = CNT_W + 1;

  // samples already held for the current group
  logic [CNT_W-1:0]     cnt;
  logic [NL_W-1:0]      n_lanes;
  logic                 full;
  logic                 emit;
  logic [`CF_LANES-1:0] fill_mask;
  logic [`CF_TAG_W-1:0] seq;

  always_comb begin
    // lanes held once this cycle's sample is counted
    n_lanes   = {1'b0, cnt} + NL_W'(sample_valid);
    // >= so a length lowered mid-group still closes the group
    full      = sample_valid && (cnt >= group_len);
    // flush with nothing pending sends nothing
    emit      = full || (flush && n_lanes != '0);
    fill_mask = ~({`CF_LANES{1'b1}} << n_lanes);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt       <= '0;
      seq       <= '0;
      grp.valid <= 1'b0;
    end else begin
      grp.valid <= emit;
      if (emit) begin
        cnt <= '0;
        seq <= seq + 1'b1;
      end else if (sample_valid) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // lane slots double as the group payload, summer samples them with valid
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      grp.lanes[cnt].raw <= sample_data;
    end
    if (emit) begin
      grp.lane_en <= fill_mask;
      grp.tag     <= seq;
    end
  end

endmodule

// ==== logic/sum_config.sv ====
/*
 * summation config registers
 * group length (rw, addr 0) and completed-group count (ro, addr 1)
 */
`timescale 1ns/1ps

module sum_config (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cfg_we,
  input  logic               cfg_addr,
  input  logic [7:0]         cfg_wdata,
  input  logic               group_done,
  output logic [7:0]         cfg_rdata,
  output cf_pkg::group_len_t group_len
);

  localparam logic ADDR_LEN   = 1'b0;
  localparam logic ADDR_COUNT = 1'b1;

  logic [7:0] done_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      group_len <= cf_pkg::GROUP_LEN_FULL;
      done_cnt  <= '0;
    end else begin
      // count is read only, writes there are dropped
      if (cfg_we && cfg_addr == ADDR_LEN) begin
        group_len <= cf_pkg::group_len_t'(cfg_wdata);
      end
      // wraps at 256
      if (group_done) begin
        done_cnt <= done_cnt + 8'd1;
      end
    end
  end

  // read-back is combinational from the address
  always_comb begin
    case (cfg_addr)
      ADDR_COUNT: cfg_rdata = done_cnt;
      default:    cfg_rdata = 8'(group_len);
    endcase
  end

endmodule

// ==== tb.f ====
+incdir+include
logic/cf_pkg.sv
logic/cf_group_if.sv
logic/sum_config.sv
logic/lane_loader.sv
logic/group_sum.sv
logic/cf_sum_top.sv
testbench/tb_cf_sum.sv

// ==== testbench/tb_cf_sum.sv ====
/*
 * testbench for the compact float group summer
 * directed tests checked against a truncating reference model
 */
`timescale 1ns/1ps
`include "cf_macros.svh"

module tb_cf_sum;

  localparam int W            = `CF_WIDTH;
  localparam int EXP_W        = `CF_EXP_W;
  localparam int FRAC_W       = `CF_FRAC_W;
  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 10;
  // loader register plus the summer pipeline
  localparam int LATENCY      = `CF_PIPE_DEPTH + 1;
  localparam int SETTLE       = 10;
  localparam int N_SAMPLES    = 46;
  localparam int N_CFG_OPS    = 10;
  localparam int N_WAITS      = 6;
  // twice the run length the tests need
  localparam int TIMEOUT_CYCLES =
    2 * (RESET_CYCLES + N_SAMPLES + 2 * N_CFG_OPS + N_WAITS * (LATENCY + SETTLE + 2));
  // sign 1, exponent all ones, fraction msb only
  localparam logic [W-1:0] QNAN_WORD = {1'b1, 8'hff, 1'b1, 8'h00};

  logic            clk;
  logic            rst_n;
  logic            sample_valid;
  logic [W-1:0]    sample_data;
  logic            flush;
  logic            cfg_we;
  logic            cfg_addr;
  logic [7:0]      cfg_wdata;
  logic [7:0]      cfg_rdata;
  logic            result_valid;
  logic [W-1:0]    result_sum;
  logic [7:0]      result_tag;

  int              cyc = 0;
  int              total_results = 0;
  // groups sent so far, each one owes exactly one result
  int              total_expected = 0;
  int              checks;
  int              errors;
  logic [7:0]      next_tag;
  logic [31:0]     lfsr;
  logic [W-1:0]    got_sum [$];
  logic [7:0]      got_tag [$];
  int              got_cyc [$];
  logic [W-1:0]    exp_sum [$];
  logic [7:0]      exp_tag [$];
  int              exp_cyc [$];

  cf_sum_top i_cf_sum_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .flush        (flush),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .result_valid (result_valid),
    .result_sum   (result_sum),
    .result_tag   (result_tag)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped producing results", cyc);
      $display("Simulation failed");
      $finish;
    end
  end

  // outputs settle after the rising edge, so collect on the falling one
  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      got_sum.push_back(result_sum);
      got_tag.push_back(result_tag);
      got_cyc.push_back(cyc);
      total_results++;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    // taps 32, 22, 2, 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // exponents 120..135 so shifts range from none to beyond the mantissa
  task automatic rand_sample(output logic [W-1:0] v);
    logic [31:0] b;
    take_bits(14, b);
    v = {b[13], 8'd120 + {4'b0000, b[12:9]}, b[8:0]};
  endtask

  function automatic logic [W-1:0] model_sum(input logic [W-1:0] s [4], input int n);
    logic [EXP_W-1:0] emax;
    logic [EXP_W-1:0] e;
    logic             nan;
    logic [W-1:0]     r;
    int               acc;
    int               val;
    int               mag;
    int               p;
    int               f;
    emax = '0;
    nan  = 1'b0;
    acc  = 0;
    p    = 0;
    r    = '0;
    for (int i = 0; i < n; i++) begin
      e = s[i][W-2 -: EXP_W];
      if (&e && s[i][FRAC_W-1:0] != '0) nan = 1'b1;
      if (e != '0 && e > emax) emax = e;
    end
    if (nan) return QNAN_WORD;
    // exponent zero lanes add nothing
    for (int i = 0; i < n; i++) begin
      e = s[i][W-2 -: EXP_W];
      if (e != '0) begin
        val = int'({1'b1, s[i][FRAC_W-1:0]}) >> (emax - e);
        acc = s[i][W-1] ? acc - val : acc + val;
      end
    end
    if (acc == 0) return '0;
    mag = (acc < 0) ? -acc : acc;
    for (int b = 0; b < 32; b++) begin
      if (mag[b]) p = b;
    end
    f = (p >= FRAC_W) ? (mag >> (p - FRAC_W)) : (mag << (FRAC_W - p));
    r[W-1]            = (acc < 0);
    r[W-2 -: EXP_W]   = EXP_W'(int'(emax) + p - FRAC_W);
    r[FRAC_W-1:0]     = f[FRAC_W-1:0];
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got == want) else begin
      $display("FAIL %0t %s got %0h expected %0h", $time, name, got, want);
      errors++;
    end
  endtask

  task automatic drive_sample(input logic [W-1:0] d, input logic with_flush,
                              output int at_cyc);
    @(negedge clk);
    sample_valid = 1'b1;
    sample_data  = d;
    flush        = with_flush;
    at_cyc       = cyc;
  endtask

  task automatic drive_idle();
    @(negedge clk);
    sample_valid = 1'b0;
    flush        = 1'b0;
    cfg_we       = 1'b0;
  endtask

  task automatic write_cfg(input logic a, input logic [7:0] d);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = a;
    cfg_wdata = d;
    @(negedge clk);
    cfg_we    = 1'b0;
  endtask

  // read-back is combinational, sample it inside the low phase
  task automatic read_cfg(input logic a, output logic [7:0] d);
    @(negedge clk);
    cfg_addr = a;
    #(PERIOD/10);
    d = cfg_rdata;
  endtask

  // back to back samples, flush optionally riding on the last one
  task automatic send_group(input logic [W-1:0] s [4], input int n,
                            input logic flush_last, output int last_cyc);
    for (int i = 0; i < n; i++) begin
      drive_sample(s[i], flush_last && (i == n - 1), last_cyc);
    end
  endtask

  task automatic push_expect(input logic [W-1:0] sum, input int at_cyc);
    exp_sum.push_back(sum);
    exp_tag.push_back(next_tag);
    exp_cyc.push_back(at_cyc + LATENCY);
    next_tag++;
    total_expected++;
  endtask

  task automatic check_results();
    int n;
    while (got_sum.size() < exp_sum.size()) @(negedge clk);
    // extra cycles catch results that should not be there
    repeat (SETTLE) @(negedge clk);
    check_value("result count", 32'(got_sum.size()), 32'(exp_sum.size()));
    n = (got_sum.size() < exp_sum.size()) ? got_sum.size() : exp_sum.size();
    for (int i = 0; i < n; i++) begin
      check_value("result_sum", 32'(got_sum[i]), 32'(exp_sum[i]));
      check_value("result_tag", 32'(got_tag[i]), 32'(exp_tag[i]));
      check_value("result_valid cycle", 32'(got_cyc[i]), 32'(exp_cyc[i]));
    end
    got_sum.delete();
    got_tag.delete();
    got_cyc.delete();
    exp_sum.delete();
    exp_tag.delete();
    exp_cyc.delete();
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic reset_state();
    int         e0;
    logic [7:0] d;
    e0 = errors;
    @(negedge clk);
    check_value("result_valid", 32'(result_valid), 32'd0);
    read_cfg(1'b0, d);
    check_value("cfg_rdata group length", 32'(d), 32'd3);
    read_cfg(1'b1, d);
    check_value("cfg_rdata group count", 32'(d), 32'd0);
    report_test("reset_state", e0);
  endtask

  task automatic full_groups();
    int           e0;
    int           last;
    logic [W-1:0] s [4];
    e0 = errors;
    for (int g = 0; g < 6; g++) begin
      for (int i = 0; i < 4; i++) begin
        rand_sample(s[i]);
      end
      send_group(s, 4, 1'b0, last);
      push_expect(model_sum(s, 4), last);
    end
    drive_idle();
    check_results();
    report_test("full_groups", e0);
  endtask

  task automatic configured_length();
    int           e0;
    int           last;
    logic [7:0]   d;
    logic [W-1:0] s [4];
    e0 = errors;
    write_cfg(1'b0, 8'd0);
    read_cfg(1'b0, d);
    check_value("cfg_rdata group length", 32'(d), 32'd0);
    for (int g = 0; g < 4; g++) begin
      rand_sample(s[0]);
      send_group(s, 1, 1'b0, last);
      // a single normal lane passes through unchanged
      push_expect(s[0], last);
    end
    drive_idle();
    write_cfg(1'b0, 8'd1);
    for (int g = 0; g < 2; g++) begin
      rand_sample(s[0]);
      rand_sample(s[1]);
      send_group(s, 2, 1'b0, last);
      push_expect(model_sum(s, 2), last);
    end
    drive_idle();
    check_results();
    write_cfg(1'b0, 8'd3);
    report_test("configured_length", e0);
  endtask

  task automatic flush_groups();
    int           e0;
    int           last;
    logic [W-1:0] s [4];
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      rand_sample(s[i]);
    end
    // third sample arrives together with the flush
    send_group(s, 3, 1'b1, last);
    push_expect(model_sum(s, 3), last);
    drive_idle();
    @(negedge clk);
    flush = 1'b1;
    drive_idle();
    check_results();
    report_test("flush_groups", e0);
  endtask

  task automatic special_values();
    int           e0;
    int           last;
    logic [W-1:0] s [4];
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      rand_sample(s[i]);
    end
    s[1] = {1'b0, 8'hff, 9'h001};
    send_group(s, 4, 1'b0, last);
    push_expect(QNAN_WORD, last);
    rand_sample(s[0]);
    s[1] = s[0] ^ 18'h20000;
    send_group(s, 2, 1'b1, last);
    push_expect('0, last);
    // positive zero, negative zero and an exponent zero lane with a fraction
    s[0] = '0;
    s[1] = 18'h20000;
    s[2] = {1'b0, 8'h00, 9'h1ff};
    s[3] = '0;
    send_group(s, 4, 1'b0, last);
    push_expect('0, last);
    drive_idle();
    check_results();
    report_test("special_values", e0);
  endtask

  task automatic group_counter();
    int         e0;
    logic [7:0] d;
    e0 = errors;
    read_cfg(1'b1, d);
    check_value("cfg_rdata group count", 32'(d), 32'(total_expected % 256));
    report_test("group_counter", e0);
  endtask

  initial begin
    lfsr         = 32'h91a0;
    checks       = 0;
    errors       = 0;
    next_tag     = '0;
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    sample_data  = '0;
    flush        = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = 1'b0;
    cfg_wdata    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_state();
    full_groups();
    configured_length();
    flush_groups();
    special_values();
    group_counter();
    $display("checks %0d, errors %0d, results %0d", checks, errors, total_results);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
